// ==== design/gap_cfg.svh ====
/*
 * Build-time sizes for the gap inserter.
 * A packet holds 1 to GAP_TXDEPTH words, and never more than GAP_LATENCY - 2.
 * Counters and tx_len share GAP_PAW bits, so GAP_LATENCY must stay below 2**GAP_PAW.
 */
`ifndef GAP_CFG_SVH
`define GAP_CFG_SVH

// width of one stream data word
`define GAP_DW 16

// width of the idle and delay counters, and of tx_len
`define GAP_PAW 4

// stages in the main stream delay line, which is also the look-ahead distance
`define GAP_LATENCY 12

// words in the packet buffer, and the largest legal tx_len
`define GAP_TXDEPTH 8

`endif

// ==== design/gap_pkg.sv ====
/*
 * Types shared by the gap inserter blocks.
 * The stream word carries data and the scanner busy flag together.
 */
`default_nettype none

`include "gap_cfg.svh"

package gap_pkg;

	// controller states, in the order a request moves through them
	typedef enum logic [1:0] {
		st_wait_rts,
		st_wait_gap,
		st_wait_rising,
		st_wait_falling
	} gap_state_t;

	// one stream slot as it moves down the delay line
	// busy low marks an idle slot that a packet word may replace
	typedef struct packed {
		logic [`GAP_DW-1:0] data;
		logic               busy;
	} stream_word_t;

endpackage

`default_nettype wire

// ==== design/gap_ctrl_if.sv ====
/*
 * Control link between the gap state machine and its counters.
 * The counters answer a command one cycle after it is given.
 */
`timescale 1ns/100ps
`default_nettype none

`include "gap_cfg.svh"

interface gap_ctrl_if;

	// idle cycles seen before the current one, saturating
	logic [`GAP_PAW-1:0] run_len;
	// high while the current input slot is idle
	logic                cur_idle;
	// general purpose count used for the rising delay and the window
	logic [`GAP_PAW-1:0] delay_cnt;
	// commands from the state machine, clear wins over increment
	logic                cnt_clear;
	logic                cnt_inc;
	// state view, so the counters can check their commands
	gap_pkg::gap_state_t state;

	modport fsm (
		input  run_len, cur_idle, delay_cnt,
		output cnt_clear, cnt_inc, state
	);

	modport timer (
		output run_len, cur_idle, delay_cnt,
		input  cnt_clear, cnt_inc, state
	);

endinterface

`default_nettype wire

// ==== design/gap_fsm.sv ====
/*
 * Request, gap search and clear-to-send window control.
 * tx_len must lie between 1 and GAP_LATENCY - 2 when a request is accepted.
 * The window opens GAP_LATENCY - tx_len cycles after the detection cycle.
 */
`timescale 1ns/100ps
`default_nettype none

`include "gap_cfg.svh"

module gap_fsm (
	input  logic                clk,
	input  logic                rst,
	gap_ctrl_if.fsm             ctrl,
	input  logic                request_to_send,
	input  logic [`GAP_PAW-1:0] tx_len,
	output logic                tx_ready,
	output logic                clear_to_send,
	output logic [`GAP_PAW-1:0] rd_index,
	output logic                tx_done
);

	// last delay count of the rising wait, GAP_LATENCY - 1 before the length is taken off
	localparam logic [`GAP_PAW-1:0] LAT_M1 = `GAP_LATENCY - 1;

	gap_pkg::gap_state_t state;
	logic [`GAP_PAW-1:0] len_l;
	logic [`GAP_PAW:0]   run_now;
	logic                gap_found;
	logic                rise_due;
	logic                last_word;

	// the idle run including this cycle, one bit wider so a full run cannot wrap
	assign run_now = {1'b0, ctrl.run_len} + 1'b1;

	// this cycle closes an idle run at least as long as the packet
	assign gap_found = ctrl.cur_idle && (run_now >= {1'b0, len_l});

	// the detected gap reaches the output on the next cycle
	assign rise_due = ctrl.delay_cnt == (LAT_M1 - len_l);

	// the window is on its final packet word
	assign last_word = ctrl.delay_cnt == (len_l - 1'b1);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= gap_pkg::st_wait_rts;
			len_l <= '0;
			clear_to_send <= 1'b0;
		end else begin
			case (state)
				gap_pkg::st_wait_rts: begin
					// tx_ready is high here, so a request alone means acceptance
					if (request_to_send) begin
						len_l <= tx_len;
						state <= gap_pkg::st_wait_gap;
					end
				end
				gap_pkg::st_wait_gap: begin
					if (gap_found) begin
						state <= gap_pkg::st_wait_rising;
					end
				end
				gap_pkg::st_wait_rising: begin
					if (rise_due) begin
						state <= gap_pkg::st_wait_falling;
						clear_to_send <= 1'b1;
					end
				end
				default: begin
					if (last_word) begin
						state <= gap_pkg::st_wait_rts;
						clear_to_send <= 1'b0;
					end
				end
			endcase
		end
	end

	// the delay count restarts on detection and again when the window opens
	assign ctrl.cnt_clear = (state == gap_pkg::st_wait_gap) ||
		((state == gap_pkg::st_wait_rising) && rise_due);
	assign ctrl.cnt_inc = (state == gap_pkg::st_wait_rising) ||
		(state == gap_pkg::st_wait_falling);
	assign ctrl.state = state;

	assign tx_ready = state == gap_pkg::st_wait_rts;

	// inside the window the delay count is the packet word index
	assign rd_index = (state == gap_pkg::st_wait_falling) ? ctrl.delay_cnt : '0;

	// one pulse, together with the last inserted word
	assign tx_done = (state == gap_pkg::st_wait_falling) && last_word;

	// the window register has to track the state it was set for
	a_cts_in_window : assert property (@(posedge clk) disable iff (rst)
		clear_to_send |-> state == gap_pkg::st_wait_falling);

	// a length outside this range would misplace the window
	a_len_range : assert property (@(posedge clk) disable iff (rst)
		state != gap_pkg::st_wait_rts |->
		(len_l >= 1) && (len_l <= `GAP_LATENCY - 2));

endmodule

`default_nettype wire

// ==== design/gap_timer.sv ====
/*
 * Idle run counter and the delay counter for the state machine.
 * Both counts show their new value one cycle after the input that caused it.
 */
`timescale 1ns/100ps
`default_nettype none

`include "gap_cfg.svh"

module gap_timer (
	input  logic    clk,
	input  logic    rst,
	gap_ctrl_if.timer ctrl,
	input  logic    in_busy
);

	// the run counter holds at all ones since any longer run qualifies as well
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl.run_len <= '0;
		end else if (in_busy) begin
			ctrl.run_len <= '0;
		end else if (ctrl.run_len != '1) begin
			ctrl.run_len <= ctrl.run_len + 1'b1;
		end
	end

	// the state machine combines the registered run with this cycle
	assign ctrl.cur_idle = !in_busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl.delay_cnt <= '0;
		end else if (ctrl.cnt_clear) begin
			ctrl.delay_cnt <= '0;
		end else if (ctrl.cnt_inc) begin
			ctrl.delay_cnt <= ctrl.delay_cnt + 1'b1;
		end
	end

	// a wrapped count would fire the window at the wrong slot
	a_no_wrap : assert property (@(posedge clk) disable iff (rst)
		ctrl.cnt_inc && !ctrl.cnt_clear |-> ctrl.delay_cnt != '1);

	// while a gap travels to the output the count stays short of the full delay line
	a_rise_bound : assert property (@(posedge clk) disable iff (rst)
		ctrl.state == gap_pkg::st_wait_rising |-> ctrl.delay_cnt < `GAP_LATENCY - 1);

endmodule

`default_nettype wire

// ==== design/stream_delay.sv ====
/*
 * Fixed delay line of GAP_LATENCY stages for the main stream.
 * Reset fills the line with idle zero slots.
 */
`timescale 1ns/100ps
`default_nettype none

`include "gap_cfg.svh"

module stream_delay (
	input  logic                  clk,
	input  logic                  rst,
	input  gap_pkg::stream_word_t in_word,
	output gap_pkg::stream_word_t out_word
);

	// stage 0 takes the input, the last stage feeds the output
	gap_pkg::stream_word_t stage [`GAP_LATENCY];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `GAP_LATENCY; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= in_word;
			for (int i = 1; i < `GAP_LATENCY; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	// a word sampled in cycle t shows up here in cycle t + GAP_LATENCY
	assign out_word = stage[`GAP_LATENCY-1];

endmodule

`default_nettype wire

// ==== design/tx_buffer.sv ====
/*
 * Packet word store with a combinational read port.
 * The host writes only while tx_ready is high, addresses below GAP_TXDEPTH.
 */
`timescale 1ns/100ps
`default_nettype none

`include "gap_cfg.svh"

module tx_buffer (
	input  logic                clk,
	input  logic                wr_en,
	input  logic [`GAP_PAW-1:0] wr_addr,
	input  logic [`GAP_DW-1:0]  wr_data,
	input  logic [`GAP_PAW-1:0] rd_index,
	output logic [`GAP_DW-1:0]  rd_data
);

	// the store needs fewer address bits than the counters carry
	localparam int AW = $clog2(`GAP_TXDEPTH);

	logic [`GAP_DW-1:0] mem [`GAP_TXDEPTH];
	logic [AW-1:0]      wr_sel;
	logic [AW-1:0]      rd_sel;

	assign wr_sel = wr_addr[AW-1:0];
	assign rd_sel = rd_index[AW-1:0];

	// the host loads one packet word per write strobe
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_sel] <= wr_data;
		end
	end

	// the word must be ready in the same cycle the window selects it
	assign rd_data = mem[rd_sel];

	// an address past the end would silently alias a lower word
	a_wr_addr : assert property (@(posedge clk)
		wr_en |-> wr_addr < `GAP_TXDEPTH);

	// the window index stays inside the store as long as tx_len does
	a_rd_index : assert property (@(posedge clk)
		rd_index < `GAP_TXDEPTH);

endmodule

`default_nettype wire

// ==== design/stream_mux.sv ====
/*
 * Output select between the delayed stream and packet words.
 * Purely combinational, timing follows the delay line and the window.
 */
`timescale 1ns/100ps
`default_nettype none

`include "gap_cfg.svh"

module stream_mux (
	input  logic                  clear_to_send,
	input  gap_pkg::stream_word_t delayed,
	input  logic [`GAP_DW-1:0]    tx_data,
	output logic [`GAP_DW-1:0]    out_data,
	output logic                  out_valid
);

	// inside the window the packet word takes the idle slot
	assign out_data = clear_to_send ? tx_data : delayed.data;

	// a slot is valid if it carries scanner traffic or an inserted word
	assign out_valid = clear_to_send || delayed.busy;

	// the window may only ever fall on slots that were idle at the input,
	// otherwise scanner traffic would be lost here
	always_comb begin
		a_no_collision : assert final (!(clear_to_send && delayed.busy));
	end

endmodule

`default_nettype wire

// ==== design/gap_inserter_top.sv ====
/*
 * Gap inserter top level with plain ports.
 * The output follows the input GAP_LATENCY cycles later, apart from inserted slots.
 * There is no stream back-pressure, tx_ready is the only flow control.
 */
`timescale 1ns/100ps
`default_nettype none

`include "gap_cfg.svh"

module gap_inserter_top (
	input  logic                clk,
	input  logic                rst,
	input  logic [`GAP_DW-1:0]  in_data,
	input  logic                in_busy,
	input  logic                tx_wr_en,
	input  logic [`GAP_PAW-1:0] tx_wr_addr,
	input  logic [`GAP_DW-1:0]  tx_wr_data,
	input  logic [`GAP_PAW-1:0] tx_len,
	input  logic                request_to_send,
	output logic                tx_ready,
	output logic                tx_done,
	output logic [`GAP_DW-1:0]  out_data,
	output logic                out_valid
);

	gap_pkg::stream_word_t in_word;
	gap_pkg::stream_word_t delayed;
	logic                  clear_to_send;
	logic [`GAP_PAW-1:0]   rd_index;
	logic [`GAP_DW-1:0]    tx_data;

	gap_ctrl_if ctrl ();

	// the scanner slot enters the delay line as one word
	assign in_word.data = in_data;
	assign in_word.busy = in_busy;

	gap_fsm gap_fsm_inst (
		.clk             (clk),
		.rst             (rst),
		.ctrl            (ctrl),
		.request_to_send (request_to_send),
		.tx_len          (tx_len),
		.tx_ready        (tx_ready),
		.clear_to_send   (clear_to_send),
		.rd_index        (rd_index),
		.tx_done         (tx_done)
	);

	// the counters see the undelayed input, which gives the look-ahead
	gap_timer gap_timer_inst (
		.clk     (clk),
		.rst     (rst),
		.ctrl    (ctrl),
		.in_busy (in_busy)
	);

	stream_delay stream_delay_inst (
		.clk      (clk),
		.rst      (rst),
		.in_word  (in_word),
		.out_word (delayed)
	);

	tx_buffer tx_buffer_inst (
		.clk      (clk),
		.wr_en    (tx_wr_en),
		.wr_addr  (tx_wr_addr),
		.wr_data  (tx_wr_data),
		.rd_index (rd_index),
		.rd_data  (tx_data)
	);

	stream_mux stream_mux_inst (
		.clear_to_send (clear_to_send),
		.delayed       (delayed),
		.tx_data       (tx_data),
		.out_data      (out_data),
		.out_valid     (out_valid)
	);

endmodule

`default_nettype wire

// ==== bench/gap_inserter_chk.sv ====
/*
 * Output checker for the gap inserter testbench.
 * Expected values must be stable before each rising edge, where they are compared.
 */
`timescale 1ns/100ps
`default_nettype none

`include "gap_cfg.svh"

module gap_inserter_chk (
	input  logic               clk,
	input  logic               en,
	input  logic [3:0]         phase,
	input  logic [`GAP_DW-1:0] out_data,
	input  logic               out_valid,
	input  logic               tx_ready,
	input  logic               tx_done,
	input  logic [`GAP_DW-1:0] exp_data,
	input  logic               exp_valid,
	input  logic               exp_ready,
	input  logic               exp_done,
	output int                 errors,
	output int                 checks
);

	int err_count = 0;
	int chk_count = 0;

	assign errors = err_count;
	assign checks = chk_count;

	// phase numbers as the stimulus sets them
	function automatic string phase_name(input logic [3:0] p);
		case (p)
			4'd1: return "pass_through";
			4'd2: return "long_gap";
			4'd3: return "short_gaps";
			4'd4: return "running_gap";
			4'd5: return "length_limits";
			4'd6: return "random_traffic";
			default: return "reset";
		endcase
	endfunction

	task automatic compare(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			err_count = err_count + 1;
			$display("error in %s: %s expected %0h, actual %0h at %0t",
				phase_name(phase), what, expected, actual, $time);
		end
	endtask

	// DUT outputs read here are the values from just before the edge
	always @(posedge clk) begin
		if (en) begin
			chk_count = chk_count + 1;
			compare("out_valid", 32'(exp_valid), 32'(out_valid));
			compare("out_data", 32'(exp_data), 32'(out_data));
			compare("tx_ready", 32'(exp_ready), 32'(tx_ready));
			compare("tx_done", 32'(exp_done), 32'(tx_done));
		end
	end

endmodule

`default_nettype wire

// ==== bench/gap_inserter_tb.sv ====
/*
 * Testbench for the gap inserter with a cycle level reference model.
 * Inputs change on falling edges, outputs are compared on rising edges.
 * Packet lengths stay within the buffer depth and GAP_LATENCY - 2.
 */
`timescale 1ns/100ps
`default_nettype none

`include "gap_cfg.svh"

module gap_inserter_tb;

	localparam int LAT = `GAP_LATENCY;
	localparam int MAX_LEN = (`GAP_TXDEPTH < LAT - 2) ? `GAP_TXDEPTH : LAT - 2;
	localparam int MAX_CYC = 8192;
	localparam int MAX_REQ = 64;
	localparam int TIMEOUT = 1000;

	logic               clk;
	logic               rst;
	logic [`GAP_DW-1:0] in_data;
	logic               in_busy;
	logic               tx_wr_en;
	logic [`GAP_PAW-1:0] tx_wr_addr;
	logic [`GAP_DW-1:0] tx_wr_data;
	logic [`GAP_PAW-1:0] tx_len;
	logic               request_to_send;
	logic               tx_ready;
	logic               tx_done;
	logic [`GAP_DW-1:0] out_data;
	logic               out_valid;

	// expected values for the coming rising edge
	logic               exp_en = 1'b0;
	logic [`GAP_DW-1:0] exp_data = '0;
	logic               exp_valid = 1'b0;
	logic               exp_ready = 1'b1;
	logic               exp_done = 1'b0;
	logic [3:0]         phase = 4'd0;
	int                 errors;
	int                 checks;

	// input history by rising edge index, and the host's copy of the packet buffer
	logic               hist_busy [MAX_CYC];
	logic [`GAP_DW-1:0] hist_data [MAX_CYC];
	logic [`GAP_DW-1:0] buf_img [`GAP_TXDEPTH];
	// accepted requests whose detection cycle stays -1 until the gap is seen
	int                 req_acc [MAX_REQ];
	int                 req_len [MAX_REQ];
	int                 req_det [MAX_REQ];
	logic [`GAP_DW-1:0] req_words [MAX_REQ][`GAP_TXDEPTH];
	int                 num_req = 0;
	int                 cyc = 0;
	int                 last_rst = -1;
	int                 timeouts = 0;
	logic               timed_out = 1'b0;
	int unsigned        busy_pct = 100;
	bit                 pat [$];

	gap_inserter_top gap_inserter_top_inst (
		.clk             (clk),
		.rst             (rst),
		.in_data         (in_data),
		.in_busy         (in_busy),
		.tx_wr_en        (tx_wr_en),
		.tx_wr_addr      (tx_wr_addr),
		.tx_wr_data      (tx_wr_data),
		.tx_len          (tx_len),
		.request_to_send (request_to_send),
		.tx_ready        (tx_ready),
		.tx_done         (tx_done),
		.out_data        (out_data),
		.out_valid       (out_valid)
	);

	gap_inserter_chk gap_inserter_chk_inst (
		.clk       (clk),
		.en        (exp_en),
		.phase     (phase),
		.out_data  (out_data),
		.out_valid (out_valid),
		.tx_ready  (tx_ready),
		.tx_done   (tx_done),
		.exp_data  (exp_data),
		.exp_valid (exp_valid),
		.exp_ready (exp_ready),
		.exp_done  (exp_done),
		.errors    (errors),
		.checks    (checks)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// first cycle after acceptance that closes an idle run of the packet length
	function automatic int detect_cycle(input int r, input int limit);
		int run;
		for (int c = req_acc[r] + 1; c <= limit; c++) begin
			run = 0;
			while (run < req_len[r] && c - run > last_rst && !hist_busy[c - run]) begin
				run = run + 1;
			end
			if (run >= req_len[r]) begin
				return c;
			end
		end
		return -1;
	endfunction

	// record what the DUT sampled, and the requests that the handshake accepts
	always @(posedge clk) begin
		hist_busy[cyc] = in_busy;
		hist_data[cyc] = in_data;
		if (rst) begin
			last_rst = cyc;
		end else begin
			if (tx_wr_en) begin
				buf_img[int'(tx_wr_addr)] = tx_wr_data;
			end
			if (request_to_send && exp_ready && num_req < MAX_REQ) begin
				req_acc[num_req] = cyc;
				req_len[num_req] = int'(tx_len);
				req_det[num_req] = -1;
				for (int i = 0; i < `GAP_TXDEPTH; i++) begin
					req_words[num_req][i] = buf_img[i];
				end
				num_req = num_req + 1;
			end
		end
		cyc = cyc + 1;
	end

	// slot m shows the input of edge m - LAT unless a packet window covers it
	always @(negedge clk) begin
		int m;
		int src;
		int c;
		m = cyc;
		src = m - LAT;
		exp_en = last_rst >= 0;
		exp_ready = 1'b1;
		exp_done = 1'b0;
		exp_valid = (src > last_rst) ? hist_busy[src] : 1'b0;
		exp_data = (src > last_rst) ? hist_data[src] : '0;
		for (int r = 0; r < num_req; r++) begin
			if (req_det[r] < 0) begin
				req_det[r] = detect_cycle(r, m - 1);
			end
			c = req_det[r];
			// busy from acceptance until the last word has gone out
			if (m > req_acc[r] && (c < 0 || m <= c + LAT)) begin
				exp_ready = 1'b0;
			end
			if (c >= 0 && src > c - req_len[r] && src <= c) begin
				exp_valid = 1'b1;
				exp_data = req_words[r][src - c + req_len[r] - 1];
				exp_done = src == c;
			end
		end
	end

	// advances one stream slot and drops the host strobes unless the caller sets them again
	task automatic step();
		@(negedge clk);
		tx_wr_en = 1'b0;
		request_to_send = 1'b0;
		if (pat.size() > 0) begin
			in_busy = pat.pop_front();
		end else begin
			in_busy = $urandom_range(99) < busy_pct;
		end
		in_data = `GAP_DW'($urandom());
	endtask

	task automatic push_run(input bit busy, input int n);
		repeat (n) pat.push_back(busy);
	endtask

	// loads len words, then raises request_to_send for one cycle
	task automatic send(input int len);
		int waited;
		waited = 0;
		while (!tx_ready && !timed_out) begin
			step();
			waited = waited + 1;
			if (waited > TIMEOUT) begin
				$display("timeout: tx_ready stayed low for %0d cycles", TIMEOUT);
				timeouts = timeouts + 1;
				timed_out = 1'b1;
			end
		end
		if (!timed_out) begin
			for (int i = 0; i < len; i++) begin
				step();
				tx_wr_en = 1'b1;
				tx_wr_addr = `GAP_PAW'(i);
				tx_wr_data = `GAP_DW'($urandom());
			end
			step();
			tx_len = `GAP_PAW'(len);
			request_to_send = 1'b1;
		end
	endtask

	// returns one cycle after tx_done, when tx_ready is back
	task automatic wait_done();
		int waited;
		waited = 0;
		while (!tx_done && !timed_out) begin
			step();
			waited = waited + 1;
			if (waited > TIMEOUT) begin
				$display("timeout: no tx_done within %0d cycles", TIMEOUT);
				timeouts = timeouts + 1;
				timed_out = 1'b1;
			end
		end
		if (!timed_out) begin
			step();
		end
	endtask

	initial begin
		void'($urandom(99));
		rst = 1'b1;
		in_busy = 1'b1;
		in_data = '0;
		tx_wr_en = 1'b0;
		tx_wr_addr = '0;
		tx_wr_data = '0;
		tx_len = '0;
		request_to_send = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		phase = 4'd1;
		busy_pct = 50;
		repeat (40) step();

		// all busy unless a pattern says otherwise
		phase = 4'd2;
		busy_pct = 100;
		send(4);
		push_run(1'b1, 5);
		push_run(1'b0, 6);
		wait_done();

		phase = 4'd3;
		send(6);
		push_run(1'b0, 3);
		push_run(1'b1, 2);
		push_run(1'b0, 5);
		push_run(1'b1, 1);
		push_run(1'b0, 8);
		wait_done();

		// three idle slots up to the acceptance edge and two after it complete the run
		phase = 4'd4;
		push_run(1'b1, 3);
		push_run(1'b0, 3);
		send(5);
		push_run(1'b0, 4);
		wait_done();

		phase = 4'd5;
		busy_pct = 50;
		send(1);
		wait_done();
		busy_pct = 30;
		send(MAX_LEN);
		wait_done();

		phase = 4'd6;
		repeat (30) begin
			busy_pct = 20 + $urandom_range(20);
			send(1 + int'($urandom_range(MAX_LEN - 1)));
			wait_done();
		end

		// let the last slots drain through the delay line
		busy_pct = 50;
		repeat (LAT + 4) step();
		@(negedge clk);
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
design/gap_pkg.sv
design/gap_ctrl_if.sv
design/gap_fsm.sv
design/gap_timer.sv
design/stream_delay.sv
design/tx_buffer.sv
design/stream_mux.sv
design/gap_inserter_top.sv
bench/gap_inserter_chk.sv
bench/gap_inserter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the gap inserter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module gap_inserter_tb -f tb.f -o gap_sim

./obj_dir/gap_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
	exit 0
fi
echo "testbench did not pass, see sim.log"
exit 1
